/* source/rv_pkg.sv */
package rv_pkg;

   // Data path and address width
   parameter int unsigned XLEN = 32;

   typedef logic [XLEN-1:0] xlen_t;
   typedef logic [4:0]      reg_addr_t;

   // Major opcodes the core still decodes
   typedef enum logic [6:0] {
      OP     = 7'b0110011,     // ADD SUB AND OR
      OP_IMM = 7'b0010011,     // ADDI
      LOAD   = 7'b0000011,     // LW
      STORE  = 7'b0100011,     // SW
      BRANCH = 7'b1100011,     // BEQ
      JAL    = 7'b1101111
   } opcode_e;

   typedef enum logic [1:0] {
      ALU_ADD = 2'b00,
      ALU_SUB = 2'b01,
      ALU_AND = 2'b10,
      ALU_OR  = 2'b11
   } alu_op_e;

   // Source of an operand in execute
   typedef enum logic [1:0] {
      FWD_RF  = 2'b00,         // Value read in decode
      FWD_MEM = 2'b01,         // Result now in memory stage
      FWD_WB  = 2'b10          // Result now in writeback stage
   } fwd_sel_e;

   // ADDI x0,x0,0 used as pipeline bubble
   parameter xlen_t NOP_INSTR = 32'h0000_0013;

endpackage

/* source/rv_regfile.sv */
`timescale 1ns/10ps

module rv_regfile (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  rv_pkg::reg_addr_t rs1_i,
   input  rv_pkg::reg_addr_t rs2_i,
   input  rv_pkg::reg_addr_t rd_i,
   input  rv_pkg::xlen_t     rd_data_i,
   input  logic              rd_we_i,
   output rv_pkg::xlen_t     rs1_data_o,
   output rv_pkg::xlen_t     rs2_data_o
);
   import rv_pkg::*;

   xlen_t regs_q [1:31];                         // x0 has no storage

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 1; i < 32; i++) begin
            regs_q[i] <= '0;
         end
      end else if (rd_we_i && (rd_i != '0)) begin
         regs_q[rd_i] <= rd_data_i;
      end
   end

   // A write in progress is seen by the read
   function automatic xlen_t read_port(input reg_addr_t addr);
      if (addr == '0) begin
         return '0;
      end
      if (rd_we_i && (rd_i == addr)) begin
         return rd_data_i;
      end
      return regs_q[addr];
   endfunction

   assign rs1_data_o = read_port(rs1_i);
   assign rs2_data_o = read_port(rs2_i);

endmodule

/* source/rv_hazard.sv */
`timescale 1ns/10ps

module rv_hazard (
   input  rv_pkg::reg_addr_t dec_rs1_i,
   input  rv_pkg::reg_addr_t dec_rs2_i,
   input  rv_pkg::reg_addr_t ex_rs1_i,
   input  rv_pkg::reg_addr_t ex_rs2_i,
   input  rv_pkg::reg_addr_t ex_rd_i,
   input  rv_pkg::reg_addr_t mem_rd_i,
   input  rv_pkg::reg_addr_t wb_rd_i,
   input  logic              ex_mem_read_i,
   input  logic              mem_reg_write_i,
   input  logic              wb_reg_write_i,
   output rv_pkg::fwd_sel_e  fwd_a_o,
   output rv_pkg::fwd_sel_e  fwd_b_o,
   output logic              load_stall_o
);
   import rv_pkg::*;

   logic load_rd_valid;

   // Memory stage holds the younger result, so it is checked first
   function automatic fwd_sel_e select_src(input reg_addr_t src);
      if (mem_reg_write_i && (mem_rd_i != '0) && (mem_rd_i == src)) begin
         return FWD_MEM;
      end
      if (wb_reg_write_i && (wb_rd_i != '0) && (wb_rd_i == src)) begin
         return FWD_WB;
      end
      return FWD_RF;
   endfunction

   assign fwd_a_o = select_src(ex_rs1_i);
   assign fwd_b_o = select_src(ex_rs2_i);

   // Load data only exists once the load reaches memory
   assign load_rd_valid = ex_mem_read_i && (ex_rd_i != '0);
   assign load_stall_o  = load_rd_valid &&
                          ((ex_rd_i == dec_rs1_i) || (ex_rd_i == dec_rs2_i));

endmodule

/* source/rv_fetch.sv */
`timescale 1ns/10ps

module rv_fetch #(
   parameter rv_pkg::xlen_t RESET_PC = '0
) (
   input  logic          clk_i,
   input  logic          rst_n_i,
   input  rv_pkg::xlen_t inst_i,
   input  logic          load_stall_i,
   input  logic          jal_take_i,
   input  rv_pkg::xlen_t jal_target_i,
   input  logic          branch_take_i,
   input  rv_pkg::xlen_t branch_target_i,
   output rv_pkg::xlen_t inst_addr_o,
   output logic          inst_ce_o,
   output rv_pkg::xlen_t if_pc_o,
   output rv_pkg::xlen_t if_instr_o
);
   import rv_pkg::*;

   xlen_t pc_q;
   xlen_t pc_d;
   logic  ce_q;                                  // Fetch runs one cycle after reset

   assign inst_addr_o = pc_q;
   assign inst_ce_o   = ce_q;

   // Branch in execute is older than JAL in decode
   always_comb begin
      if (!ce_q) begin
         pc_d = pc_q;
      end else if (branch_take_i) begin
         pc_d = branch_target_i;
      end else if (load_stall_i) begin
         pc_d = pc_q;                             // Refetch same word
      end else if (jal_take_i) begin
         pc_d = jal_target_i;
      end else begin
         pc_d = pc_q + 32'd4;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ce_q       <= 1'b0;
         pc_q       <= RESET_PC;
         if_instr_o <= NOP_INSTR;
      end else begin
         ce_q <= 1'b1;
         pc_q <= pc_d;
         if (!ce_q || branch_take_i) begin
            if_instr_o <= NOP_INSTR;
         end else if (!load_stall_i) begin
            if_instr_o <= jal_take_i ? NOP_INSTR : inst_i;  // Squash word after JAL
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!load_stall_i) begin
         if_pc_o <= pc_q;
      end
   end

endmodule

/* source/rv_decode.sv */
`timescale 1ns/10ps

module rv_decode (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  rv_pkg::xlen_t     if_pc_i,
   input  rv_pkg::xlen_t     if_instr_i,
   input  rv_pkg::xlen_t     rs1_data_i,
   input  rv_pkg::xlen_t     rs2_data_i,
   input  logic              load_stall_i,
   input  logic              branch_take_i,
   output rv_pkg::reg_addr_t rs1_o,
   output rv_pkg::reg_addr_t rs2_o,
   output logic              jal_take_o,
   output rv_pkg::xlen_t     jal_target_o,
   output rv_pkg::xlen_t     id_pc_o,
   output rv_pkg::xlen_t     id_a_o,
   output rv_pkg::xlen_t     id_b_o,
   output rv_pkg::xlen_t     id_imm_o,
   output rv_pkg::reg_addr_t id_rs1_o,
   output rv_pkg::reg_addr_t id_rs2_o,
   output rv_pkg::reg_addr_t id_rd_o,
   output rv_pkg::alu_op_e   id_alu_op_o,
   output logic              id_alu_src_o,
   output logic              id_mem_read_o,
   output logic              id_mem_write_o,
   output logic              id_reg_write_o,
   output logic              id_branch_o,
   output logic              id_link_o
);
   import rv_pkg::*;

   xlen_t      imm_i;
   xlen_t      imm_s;
   xlen_t      imm_b;
   xlen_t      imm_j;
   xlen_t      imm;
   alu_op_e    alu_op;
   logic       alu_src;
   logic       mem_read;
   logic       mem_write;
   logic       reg_write;
   logic       branch;
   logic       link;
   logic [2:0] funct3;
   logic       flush;

   assign rs1_o  = if_instr_i[19:15];
   assign rs2_o  = if_instr_i[24:20];
   assign funct3 = if_instr_i[14:12];

   assign imm_i = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
   assign imm_s = {{20{if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]};
   assign imm_b = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
                   if_instr_i[30:25], if_instr_i[11:8], 1'b0};
   assign imm_j = {{11{if_instr_i[31]}}, if_instr_i[31], if_instr_i[19:12],
                   if_instr_i[20], if_instr_i[30:21], 1'b0};

   // Anything not listed decodes as a NOP
   always_comb begin
      alu_op    = ALU_ADD;
      alu_src   = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      reg_write = 1'b0;
      branch    = 1'b0;
      link      = 1'b0;
      imm       = imm_i;
      case (opcode_e'(if_instr_i[6:0]))
         OP: begin
            reg_write = (funct3 == 3'b000) || (funct3 == 3'b110) || (funct3 == 3'b111);
            case (funct3)
               3'b111:  alu_op = ALU_AND;
               3'b110:  alu_op = ALU_OR;
               default: alu_op = if_instr_i[30] ? ALU_SUB : ALU_ADD;
            endcase
         end
         OP_IMM: begin
            alu_src   = 1'b1;
            reg_write = (funct3 == 3'b000);        // ADDI only
         end
         LOAD: begin
            alu_src   = 1'b1;
            mem_read  = 1'b1;
            reg_write = 1'b1;
         end
         STORE: begin
            alu_src   = 1'b1;
            mem_write = 1'b1;
            imm       = imm_s;
         end
         BRANCH: begin
            branch = (funct3 == 3'b000);           // BEQ only
            imm    = imm_b;
         end
         JAL: begin
            link      = 1'b1;
            reg_write = 1'b1;
            imm       = imm_j;
         end
         default: ;
      endcase
   end

   assign jal_take_o   = link;
   assign jal_target_o = if_pc_i + imm_j;

   assign flush = load_stall_i || branch_take_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i || flush) begin
         id_rs1_o       <= '0;
         id_rs2_o       <= '0;
         id_rd_o        <= '0;
         id_mem_read_o  <= 1'b0;
         id_mem_write_o <= 1'b0;
         id_reg_write_o <= 1'b0;
         id_branch_o    <= 1'b0;
         id_link_o      <= 1'b0;
      end else begin
         id_rs1_o       <= rs1_o;
         id_rs2_o       <= rs2_o;
         id_rd_o        <= if_instr_i[11:7];
         id_mem_read_o  <= mem_read;
         id_mem_write_o <= mem_write;
         id_reg_write_o <= reg_write;
         id_branch_o    <= branch;
         id_link_o      <= link;
      end
   end

   always_ff @(posedge clk_i) begin
      id_pc_o      <= if_pc_i;
      id_a_o       <= rs1_data_i;
      id_b_o       <= rs2_data_i;
      id_imm_o     <= imm;
      id_alu_op_o  <= alu_op;
      id_alu_src_o <= alu_src;
   end

endmodule

/* source/rv_execute.sv */
`timescale 1ns/10ps

module rv_execute (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  rv_pkg::xlen_t     id_pc_i,
   input  rv_pkg::xlen_t     id_a_i,
   input  rv_pkg::xlen_t     id_b_i,
   input  rv_pkg::xlen_t     id_imm_i,
   input  rv_pkg::reg_addr_t id_rd_i,
   input  rv_pkg::alu_op_e   id_alu_op_i,
   input  logic              id_alu_src_i,
   input  logic              id_mem_read_i,
   input  logic              id_mem_write_i,
   input  logic              id_reg_write_i,
   input  logic              id_branch_i,
   input  logic              id_link_i,
   input  rv_pkg::fwd_sel_e  fwd_a_i,
   input  rv_pkg::fwd_sel_e  fwd_b_i,
   input  rv_pkg::xlen_t     mem_result_i,
   input  rv_pkg::xlen_t     wb_result_i,
   output logic              branch_take_o,
   output rv_pkg::xlen_t     branch_target_o,
   output rv_pkg::xlen_t     ex_result_o,
   output rv_pkg::xlen_t     ex_store_o,
   output rv_pkg::reg_addr_t ex_rd_o,
   output logic              ex_mem_read_o,
   output logic              ex_mem_write_o,
   output logic              ex_reg_write_o
);
   import rv_pkg::*;

   xlen_t op_a;
   xlen_t op_b;                                  // rs2 after forwarding, also store data
   xlen_t alu_b;
   xlen_t alu_res;

   function automatic xlen_t fwd_mux(input fwd_sel_e sel, input xlen_t rf_val);
      case (sel)
         FWD_MEM: return mem_result_i;
         FWD_WB:  return wb_result_i;
         default: return rf_val;
      endcase
   endfunction

   assign op_a  = fwd_mux(fwd_a_i, id_a_i);
   assign op_b  = fwd_mux(fwd_b_i, id_b_i);
   assign alu_b = id_alu_src_i ? id_imm_i : op_b;

   always_comb begin
      case (id_alu_op_i)
         ALU_SUB: alu_res = op_a - alu_b;
         ALU_AND: alu_res = op_a & alu_b;
         ALU_OR:  alu_res = op_a | alu_b;
         default: alu_res = op_a + alu_b;
      endcase
   end

   assign branch_take_o   = id_branch_i && (op_a == op_b);   // BEQ
   assign branch_target_o = id_pc_i + id_imm_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ex_rd_o        <= '0;
         ex_mem_read_o  <= 1'b0;
         ex_mem_write_o <= 1'b0;
         ex_reg_write_o <= 1'b0;
      end else begin
         ex_rd_o        <= id_rd_i;
         ex_mem_read_o  <= id_mem_read_i;
         ex_mem_write_o <= id_mem_write_i;
         ex_reg_write_o <= id_reg_write_i;
      end
   end

   always_ff @(posedge clk_i) begin
      ex_result_o <= id_link_i ? id_pc_i + 32'd4 : alu_res;   // JAL writes return address
      ex_store_o  <= op_b;
   end

endmodule

/* source/rv_core.sv */
`timescale 1ns/10ps

module rv_core #(
   parameter rv_pkg::xlen_t RESET_PC = '0
) (
   input  logic          clk_i,
   input  logic          rst_n_i,
   input  rv_pkg::xlen_t inst_i,
   input  rv_pkg::xlen_t data_i,
   output rv_pkg::xlen_t inst_addr_o,
   output logic          inst_ce_o,
   output rv_pkg::xlen_t data_addr_o,
   output rv_pkg::xlen_t data_o,
   output logic          data_ce_o,
   output logic          data_we_o
);
   import rv_pkg::*;

   xlen_t     if_pc;
   xlen_t     if_instr;
   reg_addr_t rs1;
   reg_addr_t rs2;
   xlen_t     rs1_data;
   xlen_t     rs2_data;
   logic      jal_take;
   xlen_t     jal_target;
   logic      branch_take;
   xlen_t     branch_target;
   logic      load_stall;
   fwd_sel_e  fwd_a;
   fwd_sel_e  fwd_b;

   xlen_t     id_pc;
   xlen_t     id_a;
   xlen_t     id_b;
   xlen_t     id_imm;
   reg_addr_t id_rs1;
   reg_addr_t id_rs2;
   reg_addr_t id_rd;
   alu_op_e   id_alu_op;
   logic      id_alu_src;
   logic      id_mem_read;
   logic      id_mem_write;
   logic      id_reg_write;
   logic      id_branch;
   logic      id_link;

   xlen_t     ex_result;
   xlen_t     ex_store;
   reg_addr_t ex_rd;
   logic      ex_mem_read;
   logic      ex_mem_write;
   logic      ex_reg_write;

   xlen_t     mem_result;                        // Value the memory stage will write back
   xlen_t     wb_result;
   reg_addr_t wb_rd;
   logic      wb_reg_write;

   rv_fetch #(
      .RESET_PC (RESET_PC)
   ) i_fetch (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .inst_i          (inst_i),
      .load_stall_i    (load_stall),
      .jal_take_i      (jal_take),
      .jal_target_i    (jal_target),
      .branch_take_i   (branch_take),
      .branch_target_i (branch_target),
      .inst_addr_o     (inst_addr_o),
      .inst_ce_o       (inst_ce_o),
      .if_pc_o         (if_pc),
      .if_instr_o      (if_instr)
   );

   rv_decode i_decode (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .if_pc_i        (if_pc),
      .if_instr_i     (if_instr),
      .rs1_data_i     (rs1_data),
      .rs2_data_i     (rs2_data),
      .load_stall_i   (load_stall),
      .branch_take_i  (branch_take),
      .rs1_o          (rs1),
      .rs2_o          (rs2),
      .jal_take_o     (jal_take),
      .jal_target_o   (jal_target),
      .id_pc_o        (id_pc),
      .id_a_o         (id_a),
      .id_b_o         (id_b),
      .id_imm_o       (id_imm),
      .id_rs1_o       (id_rs1),
      .id_rs2_o       (id_rs2),
      .id_rd_o        (id_rd),
      .id_alu_op_o    (id_alu_op),
      .id_alu_src_o   (id_alu_src),
      .id_mem_read_o  (id_mem_read),
      .id_mem_write_o (id_mem_write),
      .id_reg_write_o (id_reg_write),
      .id_branch_o    (id_branch),
      .id_link_o      (id_link)
   );

   rv_regfile i_regfile (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .rs1_i      (rs1),
      .rs2_i      (rs2),
      .rd_i       (wb_rd),
      .rd_data_i  (wb_result),
      .rd_we_i    (wb_reg_write),
      .rs1_data_o (rs1_data),
      .rs2_data_o (rs2_data)
   );

   rv_hazard i_hazard (
      .dec_rs1_i       (rs1),
      .dec_rs2_i       (rs2),
      .ex_rs1_i        (id_rs1),
      .ex_rs2_i        (id_rs2),
      .ex_rd_i         (id_rd),
      .mem_rd_i        (ex_rd),
      .wb_rd_i         (wb_rd),
      .ex_mem_read_i   (id_mem_read),
      .mem_reg_write_i (ex_reg_write),
      .wb_reg_write_i  (wb_reg_write),
      .fwd_a_o         (fwd_a),
      .fwd_b_o         (fwd_b),
      .load_stall_o    (load_stall)
   );

   rv_execute i_execute (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .id_pc_i         (id_pc),
      .id_a_i          (id_a),
      .id_b_i          (id_b),
      .id_imm_i        (id_imm),
      .id_rd_i         (id_rd),
      .id_alu_op_i     (id_alu_op),
      .id_alu_src_i    (id_alu_src),
      .id_mem_read_i   (id_mem_read),
      .id_mem_write_i  (id_mem_write),
      .id_reg_write_i  (id_reg_write),
      .id_branch_i     (id_branch),
      .id_link_i       (id_link),
      .fwd_a_i         (fwd_a),
      .fwd_b_i         (fwd_b),
      .mem_result_i    (mem_result),
      .wb_result_i     (wb_result),
      .branch_take_o   (branch_take),
      .branch_target_o (branch_target),
      .ex_result_o     (ex_result),
      .ex_store_o      (ex_store),
      .ex_rd_o         (ex_rd),
      .ex_mem_read_o   (ex_mem_read),
      .ex_mem_write_o  (ex_mem_write),
      .ex_reg_write_o  (ex_reg_write)
   );

   // Memory stage drives the data port directly
   assign data_addr_o = ex_result;
   assign data_o      = ex_store;
   assign data_ce_o   = ex_mem_read || ex_mem_write;
   assign data_we_o   = ex_mem_write;

   // Load data arrives in the same cycle
   assign mem_result = ex_mem_read ? data_i : ex_result;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wb_rd        <= '0;
         wb_reg_write <= 1'b0;
      end else begin
         wb_rd        <= ex_rd;
         wb_reg_write <= ex_reg_write;
      end
   end

   always_ff @(posedge clk_i) begin
      wb_result <= mem_result;
   end

endmodule

/* tests/tb_rv_core.sv */
`timescale 1ns/10ps

module tb_rv_core;

   localparam logic [31:0] RESET_PC      = 32'h0000_0200;
   localparam int          PROG_WORDS    = 32;
   localparam int          DMEM_WORDS    = 64;
   localparam int          N_STORES      = 8;
   localparam int          STORE_TIMEOUT = 50;           // Cycles allowed from one store to the next
   localparam int          FETCH_TIMEOUT = 10;
   localparam int          QUIET_CYCLES  = 40;

   localparam logic [6:0]  OPC_OP        = 7'b0110011;
   localparam logic [6:0]  OPC_OP_IMM    = 7'b0010011;
   localparam logic [6:0]  OPC_LOAD      = 7'b0000011;
   localparam logic [31:0] HALT          = 32'h0000_006F; // JAL x0,0 spins in place

   logic        clk;
   logic        rst_n;
   logic [31:0] inst;
   logic [31:0] rdata;
   logic [31:0] inst_addr;
   logic        inst_ce;
   logic [31:0] data_addr;
   logic [31:0] wdata;
   logic        data_ce;
   logic        data_we;

   logic [31:0] prog [0:PROG_WORDS-1];
   logic [31:0] dmem [0:DMEM_WORDS-1];
   logic [31:0] exp_addr [0:N_STORES-1];
   logic [31:0] exp_data [0:N_STORES-1];
   logic [31:0] inst_word;
   logic [31:0] load_word;                               // Preloaded word read by the LW
   integer      seed;

   rv_core #(
      .RESET_PC (RESET_PC)
   ) i_dut (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .inst_i      (inst),
      .data_i      (rdata),
      .inst_addr_o (inst_addr),
      .inst_ce_o   (inst_ce),
      .data_addr_o (data_addr),
      .data_o      (wdata),
      .data_ce_o   (data_ce),
      .data_we_o   (data_we)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   // Both memories answer in the same cycle
   assign inst_word = (inst_addr - RESET_PC) >> 2;

   always_comb begin
      inst = prog[inst_word[4:0]];
   end

   always_comb begin
      rdata = (data_ce && !data_we) ? dmem[data_addr[7:2]] : 'x;   // Valid only for a load
   end

   always @(posedge clk) begin
      if (data_ce && data_we) begin
         dmem[data_addr[7:2]] <= wdata;
      end
   end

   function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [2:0] funct3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
      return {funct7, rs2, rs1, funct3, rd, OPC_OP};
   endfunction

   function automatic logic [31:0] i_type(input logic [6:0] opcode, input logic [2:0] funct3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
      return {imm, rs1, funct3, rd, opcode};
   endfunction

   // Word stores (SW) only
   function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   // BEQ only
   function automatic logic [31:0] b_type(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [12:0] imm);
      return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic load_program();
      for (int i = 0; i < PROG_WORDS; i++) begin
         prog[i] = HALT;
      end
      prog[0]  = i_type(OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'h035);   // x1 = 0x35
      prog[1]  = i_type(OPC_OP_IMM, 3'b000, 5'd2, 5'd1, 12'h0F0);   // x2 = 0x125
      prog[2]  = r_type(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2);      // ADD x3 = 0x15A
      prog[3]  = r_type(7'b0100000, 3'b000, 5'd4, 5'd3, 5'd1);      // SUB x4 = 0x125
      prog[4]  = r_type(7'b0000000, 3'b111, 5'd5, 5'd4, 5'd3);      // AND x5 = 0x100
      prog[5]  = r_type(7'b0000000, 3'b110, 5'd6, 5'd5, 5'd1);      // OR x6 = 0x135
      prog[6]  = s_type(5'd6, 5'd0, 12'h080);
      prog[7]  = s_type(5'd5, 5'd0, 12'h084);
      prog[8]  = s_type(5'd3, 5'd0, 12'h088);
      prog[9]  = s_type(5'd4, 5'd0, 12'h08C);
      prog[10] = i_type(OPC_LOAD, 3'b010, 5'd7, 5'd0, 12'h010);     // LW x7 from word 4
      prog[11] = i_type(OPC_OP_IMM, 3'b000, 5'd8, 5'd7, 12'h021);   // Load-use pair
      prog[12] = s_type(5'd8, 5'd0, 12'h090);
      prog[13] = i_type(OPC_OP_IMM, 3'b000, 5'd0, 5'd0, 12'h055);   // Write to x0 is dropped
      prog[14] = s_type(5'd0, 5'd0, 12'h094);
      prog[15] = b_type(5'd1, 5'd1, 13'd12);                        // Taken so jumps to 18
      prog[16] = s_type(5'd1, 5'd0, 12'h098);
      prog[17] = s_type(5'd1, 5'd0, 12'h09C);
      prog[18] = b_type(5'd1, 5'd2, 13'd8);                         // Not taken
      prog[19] = s_type(5'd2, 5'd0, 12'h098);
      prog[20] = j_type(5'd9, 21'd8);                               // x9 = PC+4 and jumps to 22
      prog[21] = s_type(5'd1, 5'd0, 12'h0A0);
      prog[22] = s_type(5'd9, 5'd0, 12'h0A4);
   endtask

   task automatic preload_data();
      for (int i = 0; i < DMEM_WORDS; i++) begin
         dmem[i] = $random(seed);
      end
      load_word = dmem[4];
   endtask

   // Values follow from running the program in order
   task automatic fill_expected();
      exp_addr[0] = 32'h80;
      exp_data[0] = 32'h135;
      exp_addr[1] = 32'h84;
      exp_data[1] = 32'h100;
      exp_addr[2] = 32'h88;
      exp_data[2] = 32'h15A;
      exp_addr[3] = 32'h8C;
      exp_data[3] = 32'h125;
      exp_addr[4] = 32'h90;
      exp_data[4] = load_word + 32'h21;
      exp_addr[5] = 32'h94;
      exp_data[5] = 32'h0;
      exp_addr[6] = 32'h98;
      exp_data[6] = 32'h125;
      exp_addr[7] = 32'hA4;
      exp_data[7] = RESET_PC + 32'h54;                  // Link of the JAL at word 20
   endtask

   task automatic check_reset_outputs();
      assert (!inst_ce) else
         stop_on_error($sformatf("MISMATCH inst_ce_o: expected 0x0, got 0x%0h", inst_ce));
      assert (!data_ce) else
         stop_on_error($sformatf("MISMATCH data_ce_o: expected 0x0, got 0x%0h", data_ce));
      assert (!data_we) else
         stop_on_error($sformatf("MISMATCH data_we_o: expected 0x0, got 0x%0h", data_we));
   endtask

   task automatic wait_for_store(output bit seen);
      int cycles;
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < STORE_TIMEOUT) begin
         @(negedge clk);
         cycles++;
         seen = data_ce && data_we;
      end
   endtask

   initial begin
      int cycles;
      bit seen;
      rst_n = 1'b0;
      seed  = 24;
      load_program();
      preload_data();
      fill_expected();

      repeat (3) begin
         @(negedge clk);
         check_reset_outputs();
      end
      @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_reset_outputs();                             // Last edge still saw reset

      cycles = 0;
      while (!inst_ce && cycles < FETCH_TIMEOUT) begin
         @(negedge clk);
         cycles++;
         assert (!data_ce && !data_we) else
            stop_on_error("Data port active before the first fetch");
      end
      assert (inst_ce) else
         stop_on_error("Timeout waiting for inst_ce_o to rise after reset");
      assert (cycles == 1) else
         stop_on_error($sformatf("inst_ce_o rose %0d cycles after reset instead of 1", cycles));
      assert (inst_addr == RESET_PC) else
         stop_on_error($sformatf("MISMATCH inst_addr_o: expected 0x%08h, got 0x%08h",
                                 RESET_PC, inst_addr));

      for (int n = 0; n < N_STORES; n++) begin
         wait_for_store(seen);
         assert (seen) else
            stop_on_error($sformatf("Timeout waiting for store %0d", n));
         assert (data_addr == exp_addr[n]) else
            stop_on_error($sformatf(
               "MISMATCH data_addr_o (store %0d): expected 0x%08h, got 0x%08h",
               n, exp_addr[n], data_addr));
         assert (wdata == exp_data[n]) else
            stop_on_error($sformatf(
               "MISMATCH data_o (store %0d): expected 0x%08h, got 0x%08h",
               n, exp_data[n], wdata));
      end

      // Core spins on the halt loop from here on
      for (int q = 0; q < QUIET_CYCLES; q++) begin
         @(negedge clk);
         assert (!(data_ce && data_we)) else
            stop_on_error($sformatf("Unexpected store to address 0x%08h after the last one",
                                    data_addr));
         assert (inst_ce) else
            stop_on_error($sformatf("MISMATCH inst_ce_o: expected 0x1, got 0x%0h", inst_ce));
      end

      $display("Simulation passed");
      $finish;
   end

endmodule

/* verilog.f */
source/rv_pkg.sv
source/rv_regfile.sv
source/rv_hazard.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_core.sv
tests/tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - source/rv_pkg.sv
  - source/rv_regfile.sv
  - source/rv_hazard.sv
  - source/rv_fetch.sv
  - source/rv_decode.sv
  - source/rv_execute.sv
  - source/rv_core.sv
  - target: test
    files:
      - tests/tb_rv_core.sv
